/* sources.f */
+incdir+source
source/sw_pkg.sv
source/sw_links_if.sv
source/sym_loader.sv
source/sw_pe.sv
source/sw_array.sv
source/best_tracker.sv
source/result_port.sv
source/sw_top.sv
bench/tb_sw.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sw -f sources.f -o sim_tb_sw

output="$(./obj_dir/sim_tb_sw)"
echo "$output"

# a missing pass line makes grep fail, and set -e turns that into the exit status
echo "$output" | grep -q "TEST RESULT: PASS"

/* bench/tb_sw.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module tb_sw;
    import sw_pkg::*;

    localparam int MAX_JOBS    = 32;
    localparam int CREDIT_WAIT = 400;
    localparam int RESULT_WAIT = 600;

    logic               clk;
    logic               rst;
    logic               sym_valid;
    base_t              sym;
    logic               res_credit;
    logic               sym_credit;
    logic               res_valid;
    score_t             res_score;
    logic [`ROW_W-1:0]  res_row;
    logic [`COL_W-1:0]  res_col;

    int seed = 32'hc3f7;
    // base and credit bookkeeping
    int sent_total;
    int credit_total;
    int grant_limit;
    int grants_issued;
    int granted_cnt;
    int spent_cnt;
    logic hold_results;
    // expected results in job order
    logic [`SCORE_W-1:0] exp_score [MAX_JOBS];
    logic [`ROW_W-1:0]   exp_row   [MAX_JOBS];
    logic [`COL_W-1:0]   exp_col   [MAX_JOBS];
    int job_cnt;
    int res_idx;
    int val_errs;
    int proto_errs;
    int timeouts;

    sw_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .i_sym_valid  (sym_valid),
        .i_sym        (sym),
        .i_res_credit (res_credit),
        .o_sym_credit (sym_credit),
        .o_res_valid  (res_valid),
        .o_res_score  (res_score),
        .o_res_row    (res_row),
        .o_res_col    (res_col)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        credit_total <= credit_total + int'(sym_credit);
        granted_cnt  <= granted_cnt + int'(res_credit);
        spent_cnt    <= spent_cnt + int'(res_valid);
    end

    // grants result credits up to the limit, at most two unspent at a time
    initial begin
        forever begin
            @(posedge clk);
            #1;
            res_credit = (grants_issued < grant_limit) && (grants_issued - spent_cnt < 2);
            grants_issued = grants_issued + int'(res_credit);
        end
    end

    a_credit_owed: assert property (@(posedge clk) disable iff (rst)
        sym_credit |-> (sent_total > credit_total))
        else begin
            proto_errs++;
            $display("input credit returned with no base outstanding");
        end

    a_fifo_bound: assert property (@(posedge clk) disable iff (rst)
        (sent_total - credit_total) <= `FIFO_DEPTH)
        else begin
            proto_errs++;
            $display("more bases outstanding than the input FIFO holds");
        end

    a_res_spend: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> (granted_cnt > spent_cnt))
        else begin
            proto_errs++;
            $display("result sent without a result credit");
        end

    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        hold_results |-> !res_valid)
        else begin
            proto_errs++;
            $display("result sent while result credits were withheld");
        end

    always @(posedge clk) begin
        if (!rst && res_valid) begin
            a_pending: assert (res_idx < job_cnt) else begin
                proto_errs++;
                $display("result arrived with no job pending");
            end
            if (res_idx < job_cnt) begin
                a_score: assert (res_score == exp_score[res_idx]) else begin
                    val_errs++;
                    $display("mismatch o_res_score job %0d: got %h expected %h",
                             res_idx, res_score, exp_score[res_idx]);
                end
                a_row: assert (res_row == exp_row[res_idx]) else begin
                    val_errs++;
                    $display("mismatch o_res_row job %0d: got %h expected %h",
                             res_idx, res_row, exp_row[res_idx]);
                end
                a_col: assert (res_col == exp_col[res_idx]) else begin
                    val_errs++;
                    $display("mismatch o_res_col job %0d: got %h expected %h",
                             res_idx, res_col, exp_col[res_idx]);
                end
            end
            res_idx <= res_idx + 1;
        end
    end

    task automatic finish_run();
        $display("errors: %0d value, %0d protocol, %0d timeout", val_errs, proto_errs, timeouts);
        if (val_errs == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    function automatic logic [1:0] rand_base();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    function automatic int max2(int a, int b);
        return (a > b) ? a : b;
    endfunction

    // higher score, then smaller row+col, then smaller row
    function automatic logic cell_wins(int s, int r, int c, int bs, int br, int bc);
        if (s != bs) begin
            return s > bs;
        end
        if (r + c != br + bc) begin
            return r + c < br + bc;
        end
        return r < br;
    endfunction

    // Gotoh local alignment, zero boundaries for H, E and F
    task automatic model_job(input logic [2*`Q_LEN-1:0] qv, input logic [2*`R_LEN-1:0] rv,
                             output int bs, output int br, output int bc);
        int h [`Q_LEN+1][`R_LEN+1];
        int e [`Q_LEN+1][`R_LEN+1];
        int f [`Q_LEN+1][`R_LEN+1];
        int diag;
        bs = 0;
        br = 0;
        bc = 0;
        for (int i = 0; i <= `Q_LEN; i++) begin
            for (int j = 0; j <= `R_LEN; j++) begin
                h[i][j] = 0;
                e[i][j] = 0;
                f[i][j] = 0;
            end
        end
        for (int i = 1; i <= `Q_LEN; i++) begin
            for (int j = 1; j <= `R_LEN; j++) begin
                diag = h[i-1][j-1] + ((qv[2*i-2 +: 2] == rv[2*j-2 +: 2]) ?
                                      `MATCH_SCORE : `MISMATCH_SCORE);
                e[i][j] = max2(h[i][j-1] - `GAP_OPEN, e[i][j-1] - `GAP_EXTEND);
                f[i][j] = max2(h[i-1][j] - `GAP_OPEN, f[i-1][j] - `GAP_EXTEND);
                h[i][j] = max2(max2(0, diag), max2(e[i][j], f[i][j]));
                if (cell_wins(h[i][j], i - 1, j - 1, bs, br, bc)) begin
                    bs = h[i][j];
                    br = i - 1;
                    bc = j - 1;
                end
            end
        end
    endtask

    task automatic push_expect(input int s, input int r, input int c);
        exp_score[job_cnt] = s[`SCORE_W-1:0];
        exp_row[job_cnt]   = r[`ROW_W-1:0];
        exp_col[job_cnt]   = c[`COL_W-1:0];
        job_cnt++;
    endtask

    // called just after a rising edge, returns one cycle later
    task automatic send_base(input logic [1:0] b);
        int waited;
        waited = 0;
        while ((sent_total - credit_total) >= `FIFO_DEPTH && waited < CREDIT_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if ((sent_total - credit_total) >= `FIFO_DEPTH) begin
            timeouts++;
            $display("timeout waiting for an input credit");
            finish_run();
        end else begin
            sym_valid = 1'b1;
            sym = base_t'(b);
            sent_total++;
            @(posedge clk);
            #1;
            sym_valid = 1'b0;
        end
    endtask

    task automatic stream_job(input logic [2*`Q_LEN-1:0] qv, input logic [2*`R_LEN-1:0] rv);
        for (int i = 0; i < `Q_LEN; i++) begin
            send_base(qv[2*i +: 2]);
        end
        for (int j = 0; j < `R_LEN; j++) begin
            send_base(rv[2*j +: 2]);
        end
    endtask

    task automatic queue_job(input logic [2*`Q_LEN-1:0] qv, input logic [2*`R_LEN-1:0] rv);
        int s;
        int r;
        int c;
        model_job(qv, rv, s, r, c);
        push_expect(s, r, c);
        stream_job(qv, rv);
    endtask

    task automatic make_random(output logic [2*`Q_LEN-1:0] qv,
                               output logic [2*`R_LEN-1:0] rv);
        for (int i = 0; i < `Q_LEN; i++) begin
            qv[2*i +: 2] = rand_base();
        end
        for (int j = 0; j < `R_LEN; j++) begin
            rv[2*j +: 2] = rand_base();
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (res_idx < n && waited < RESULT_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (res_idx < n) begin
            timeouts++;
            $display("timeout waiting for result number %0d", n);
            finish_run();
        end
    endtask

    // previous job fully popped and the FIFO full of the next one
    task automatic wait_fifo_full(input int mark);
        int waited;
        waited = 0;
        while (!(credit_total >= mark && sent_total - credit_total == `FIFO_DEPTH)
               && waited < CREDIT_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!(credit_total >= mark && sent_total - credit_total == `FIFO_DEPTH)) begin
            timeouts++;
            $display("timeout waiting for the input FIFO to fill");
            finish_run();
        end
    endtask

    task automatic wait_credits_back();
        int waited;
        waited = 0;
        while (credit_total != sent_total && waited < CREDIT_WAIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (credit_total != sent_total) begin
            timeouts++;
            $display("input credits returned do not match the bases sent");
            finish_run();
        end
    endtask

    initial begin
        logic [2*`Q_LEN-1:0] qv;
        logic [2*`R_LEN-1:0] rv;
        int base_mark;
        int res_mark;
        rst           = 1'b1;
        sym_valid     = 1'b0;
        sym           = BASE_A;
        res_credit    = 1'b0;
        hold_results  = 1'b0;
        sent_total    = 0;
        credit_total  = 0;
        grant_limit   = 0;
        grants_issued = 0;
        granted_cnt   = 0;
        spent_cnt     = 0;
        job_cnt       = 0;
        res_idx       = 0;
        val_errs      = 0;
        proto_errs    = 0;
        timeouts      = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // exact copy of the query at columns 5..12 in a field of G
        grant_limit = 2;
        qv = 16'h1be4;
        rv = {`R_LEN{2'b10}};
        rv[2*5 +: 2*`Q_LEN] = qv;
        push_expect(16, 7, 12);
        stream_job(qv, rv);
        // all A against all C
        push_expect(0, 0, 0);
        stream_job('0, '1);
        wait_results(2);

        grant_limit += 20;
        repeat (20) begin
            make_random(qv, rv);
            queue_job(qv, rv);
        end
        wait_results(job_cnt);

        // no result credits while one job finishes and the next one waits
        hold_results = 1'b1;
        make_random(qv, rv);
        queue_job(qv, rv);
        base_mark = sent_total;
        res_mark = res_idx;
        make_random(qv, rv);
        fork
            queue_job(qv, rv);
            begin
                wait_fifo_full(base_mark);
                idle(40);
                a_stalled: assert (credit_total - base_mark <= `FIFO_DEPTH) else begin
                    proto_errs++;
                    $display("input credits kept flowing while the result was held");
                end
                hold_results = 1'b0;
                grant_limit += 1;
                wait_results(res_mark + 1);
                idle(80);
                a_one_result: assert (res_idx == res_mark + 1) else begin
                    proto_errs++;
                    $display("more than one result arrived for a single credit");
                end
                grant_limit += 1;
                wait_results(res_mark + 2);
            end
        join

        wait_credits_back();
        finish_run();
    end

endmodule

`default_nettype wire

/* source/sw_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_sym_valid,
    input  sw_pkg::base_t       i_sym,
    input  logic                i_res_credit,
    output logic                o_sym_credit,
    output logic                o_res_valid,
    output sw_pkg::score_t      o_res_score,
    output logic [`ROW_W-1:0]   o_res_row,
    output logic [`COL_W-1:0]   o_res_col
);
    import sw_pkg::*;

    array_feed_if feed_if ();
    score_row_if  score_if ();

    best_t best;
    logic  best_done;
    logic  retired;

    sym_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .i_sym_valid  (i_sym_valid),
        .i_sym        (i_sym),
        .i_retired    (retired),
        .o_sym_credit (o_sym_credit),
        .feed         (feed_if.source)
    );

    sw_array u_array (
        .clk    (clk),
        .rst    (rst),
        .feed   (feed_if.sink),
        .scores (score_if.source)
    );

    best_tracker u_tracker (
        .clk    (clk),
        .rst    (rst),
        .scores (score_if.sink),
        .o_best (best),
        .o_done (best_done)
    );

    result_port u_result (
        .clk          (clk),
        .rst          (rst),
        .i_done       (best_done),
        .i_best       (best),
        .i_res_credit (i_res_credit),
        .o_res_valid  (o_res_valid),
        .o_res_score  (o_res_score),
        .o_res_row    (o_res_row),
        .o_res_col    (o_res_col),
        .o_retired    (retired)
    );

endmodule

`default_nettype wire

/* source/result_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module result_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_done,
    input  sw_pkg::best_t       i_best,
    input  logic                i_res_credit,
    output logic                o_res_valid,
    output sw_pkg::score_t      o_res_score,
    output logic [`ROW_W-1:0]   o_res_row,
    output logic [`COL_W-1:0]   o_res_col,
    output logic                o_retired
);
    import sw_pkg::*;

    // up to 15 outstanding grants
    localparam int CRED_W = 4;

    best_t              held_best;
    logic               held;
    logic [CRED_W-1:0]  credit_cnt;
    logic               send;

    assign send = held && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (i_done) begin
            held_best <= i_best;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held       <= 1'b0;
            credit_cnt <= '0;
        end else begin
            if (i_done) begin
                held <= 1'b1;
            end else if (send) begin
                held <= 1'b0;
            end
            case ({i_res_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assign o_res_valid = send;
    assign o_res_score = held_best.score;
    assign o_res_row   = held_best.row;
    assign o_res_col   = held_best.col;
    // sending the result frees the loader for the next job
    assign o_retired   = send;

endmodule

`default_nettype wire

/* source/best_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module best_tracker (
    input  logic            clk,
    input  logic            rst,
    score_row_if.sink       scores,
    output sw_pkg::best_t   o_best,
    output logic            o_done
);
    import sw_pkg::*;

    best_t run_best;
    best_t step_best;
    best_t cand;

    // higher score wins
    // ties go to the smaller row+col, then the smaller row
    function automatic logic better(best_t a, best_t b);
        logic [`COL_W:0] sum_a;
        logic [`COL_W:0] sum_b;
        sum_a = a.row + a.col;
        sum_b = b.row + b.col;
        if (a.score != b.score) begin
            return a.score > b.score;
        end
        if (sum_a != sum_b) begin
            return sum_a < sum_b;
        end
        return a.row < b.row;
    endfunction

    // fold this step's valid lanes into the running best
    always_comb begin
        step_best = run_best;
        cand      = run_best;
        for (int i = 0; i < `Q_LEN; i++) begin
            cand.score = scores.h[i];
            cand.row   = i[`ROW_W-1:0];
            cand.col   = scores.col[i];
            if (scores.valid[i] && better(cand, step_best)) begin
                step_best = cand;
            end
        end
    end

    // empty best is score 0 at (0,0), zero cells never replace it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_best <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= scores.done;
            if (o_done) begin
                run_best <= '0;
            end else begin
                run_best <= step_best;
            end
        end
    end

    assign o_best = run_best;

endmodule

`default_nettype wire

/* source/sw_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_array (
    input  logic            clk,
    input  logic            rst,
    array_feed_if.sink      feed,
    score_row_if.source     scores
);
    import sw_pkg::*;

    // index 0 is the array input, index i+1 is the output of PE i
    logic [`Q_LEN:0]    valid_chain;
    base_t              base_chain [`Q_LEN+1];
    score_t             h_chain    [`Q_LEN+1];
    score_t             f_chain    [`Q_LEN+1];
    score_t             diag_chain [`Q_LEN+1];
    // query enters at the last PE and shifts toward PE 0
    base_t              q_chain    [`Q_LEN+1];

    logic               q_phase;
    logic               clear;
    logic [`COL_W-1:0]  col_cnt;
    logic [`COL_W-1:0]  col_pipe [`Q_LEN];
    logic [`Q_LEN-1:0]  last_pipe;

    // top row sees zero boundaries
    assign valid_chain[0]   = feed.ref_valid;
    assign base_chain[0]    = feed.ref_base;
    assign h_chain[0]       = '0;
    assign f_chain[0]       = '0;
    assign diag_chain[0]    = '0;
    assign q_chain[`Q_LEN]  = feed.q_base;

    // first query strobe of a job
    assign clear = feed.q_load && !q_phase;

    for (genvar i = 0; i < `Q_LEN; i++) begin : g_pe
        sw_pe u_pe (
            .clk      (clk),
            .rst      (rst),
            .i_clear  (clear),
            .i_q_load (feed.q_load),
            .i_q_base (q_chain[i+1]),
            .i_valid  (valid_chain[i]),
            .i_base   (base_chain[i]),
            .i_h_diag (diag_chain[i]),
            .i_h_up   (h_chain[i]),
            .i_f_up   (f_chain[i]),
            .o_q_base (q_chain[i]),
            .o_valid  (valid_chain[i+1]),
            .o_base   (base_chain[i+1]),
            .o_h      (h_chain[i+1]),
            .o_f      (f_chain[i+1]),
            .o_h_diag (diag_chain[i+1])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_phase   <= 1'b0;
            col_cnt   <= '0;
            last_pipe <= '0;
        end else begin
            if (feed.q_load) begin
                q_phase <= 1'b1;
            end else if (feed.ref_valid) begin
                q_phase <= 1'b0;
            end
            if (feed.ref_valid) begin
                col_cnt <= feed.ref_last ? '0 : col_cnt + 1'b1;
            end
            if (valid_chain[0]) begin
                last_pipe[0] <= feed.ref_last;
            end
            for (int i = 1; i < `Q_LEN; i++) begin
                if (valid_chain[i]) begin
                    last_pipe[i] <= last_pipe[i-1];
                end
            end
        end
    end

    // column tag moves with its base, one PE per step
    always_ff @(posedge clk) begin
        if (valid_chain[0]) begin
            col_pipe[0] <= col_cnt;
        end
        for (int i = 1; i < `Q_LEN; i++) begin
            if (valid_chain[i]) begin
                col_pipe[i] <= col_pipe[i-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `Q_LEN; i++) begin
            scores.h[i]   = h_chain[i+1];
            scores.col[i] = col_pipe[i];
        end
    end

    assign scores.valid = valid_chain[`Q_LEN:1];
    assign scores.done  = valid_chain[`Q_LEN] && last_pipe[`Q_LEN-1];

endmodule

`default_nettype wire

/* source/sw_pe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sw_pe (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_clear,
    input  logic            i_q_load,
    input  sw_pkg::base_t   i_q_base,
    input  logic            i_valid,
    input  sw_pkg::base_t   i_base,
    input  sw_pkg::score_t  i_h_diag,
    input  sw_pkg::score_t  i_h_up,
    input  sw_pkg::score_t  i_f_up,
    output sw_pkg::base_t   o_q_base,
    output logic            o_valid,
    output sw_pkg::base_t   o_base,
    output sw_pkg::score_t  o_h,
    output sw_pkg::score_t  o_f,
    output sw_pkg::score_t  o_h_diag
);
    import sw_pkg::*;

    base_t  q_base;
    // H and E of this row at the previous column
    score_t prev_h;
    score_t prev_e;
    score_t e_new;
    score_t f_new;
    score_t diag_new;
    score_t h_new;

    function automatic score_t max_s(score_t a, score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        e_new    = max_s(prev_h - score_t'(`GAP_OPEN), prev_e - score_t'(`GAP_EXTEND));
        f_new    = max_s(i_h_up - score_t'(`GAP_OPEN), i_f_up - score_t'(`GAP_EXTEND));
        diag_new = i_h_diag + ((i_base == q_base) ? score_t'(`MATCH_SCORE)
                                                  : score_t'(`MISMATCH_SCORE));
        // local alignment, clamp at zero
        h_new    = max_s(max_s(score_t'(0), diag_new), max_s(e_new, f_new));
    end

    // query shifts through the chain during load
    always_ff @(posedge clk) begin
        if (i_q_load) begin
            q_base <= i_q_base;
        end
    end

    assign o_q_base = q_base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_h  <= '0;
            prev_e  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_clear) begin
                prev_h <= '0;
                prev_e <= '0;
            end else if (i_valid) begin
                prev_h <= h_new;
                prev_e <= e_new;
            end
        end
    end

    // old prev_h becomes the diagonal for the next row
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_base   <= i_base;
            o_h      <= h_new;
            o_f      <= f_new;
            o_h_diag <= prev_h;
        end
    end

endmodule

`default_nettype wire

/* source/sym_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

module sym_loader (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_sym_valid,
    input  sw_pkg::base_t   i_sym,
    input  logic            i_retired,
    output logic            o_sym_credit,
    array_feed_if.source    feed
);
    import sw_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    base_t              fifo_mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     fifo_cnt;
    load_state_t        state;
    logic [`COL_W-1:0]  base_cnt;
    logic               pop;

    // no pops while a job is still draining
    assign pop = (fifo_cnt != '0) && (state != DRAIN);

    // sender never pushes without a credit, so no full check
    always_ff @(posedge clk) begin
        if (i_sym_valid) begin
            fifo_mem[wr_ptr] <= i_sym;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (i_sym_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_sym_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // popped base goes out on the next cycle with its strobe
    always_ff @(posedge clk) begin
        if (pop) begin
            feed.q_base   <= fifo_mem[rd_ptr];
            feed.ref_base <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= LOAD_QUERY;
            base_cnt       <= '0;
            o_sym_credit   <= 1'b0;
            feed.q_load    <= 1'b0;
            feed.ref_valid <= 1'b0;
            feed.ref_last  <= 1'b0;
        end else begin
            o_sym_credit   <= pop;
            feed.q_load    <= pop && (state == LOAD_QUERY);
            feed.ref_valid <= pop && (state == STREAM_REF);
            feed.ref_last  <= pop && (state == STREAM_REF) && (base_cnt == `R_LEN - 1);
            case (state)
                LOAD_QUERY: begin
                    if (pop) begin
                        if (base_cnt == `Q_LEN - 1) begin
                            base_cnt <= '0;
                            state    <= STREAM_REF;
                        end else begin
                            base_cnt <= base_cnt + 1'b1;
                        end
                    end
                end
                STREAM_REF: begin
                    if (pop) begin
                        if (base_cnt == `R_LEN - 1) begin
                            base_cnt <= '0;
                            state    <= DRAIN;
                        end else begin
                            base_cnt <= base_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // wait until the result has left the design
                    if (i_retired) begin
                        state <= LOAD_QUERY;
                    end
                end
                default: state <= LOAD_QUERY;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/sw_links_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sw_settings.svh"

// loader to PE array
interface array_feed_if;
    import sw_pkg::*;

    logic  q_load;
    base_t q_base;
    logic  ref_valid;
    base_t ref_base;
    logic  ref_last;

    modport source (output q_load, q_base, ref_valid, ref_base, ref_last);
    modport sink   (input  q_load, q_base, ref_valid, ref_base, ref_last);
endinterface

// PE array to best tracker, one lane per PE
interface score_row_if;
    import sw_pkg::*;

    score_t             h     [`Q_LEN];
    logic [`Q_LEN-1:0]  valid;
    logic [`COL_W-1:0]  col   [`Q_LEN];
    logic               done;

    modport source (output h, valid, col, done);
    modport sink   (input  h, valid, col, done);
endinterface

`default_nettype wire

/* source/sw_pkg.sv */
`default_nettype none

`include "sw_settings.svh"

package sw_pkg;

    // nucleotide codes, also used as the opcodes of the input stream
    typedef enum logic [1:0] {
        BASE_A = 2'd0,
        BASE_T = 2'd1,
        BASE_G = 2'd2,
        BASE_C = 2'd3
    } base_t;

    typedef logic signed [`SCORE_W-1:0] score_t;

    typedef enum logic [1:0] {
        LOAD_QUERY = 2'd0,
        STREAM_REF = 2'd1,
        DRAIN      = 2'd2
    } load_state_t;

    typedef struct packed {
        score_t             score;
        logic [`ROW_W-1:0]  row;
        logic [`COL_W-1:0]  col;
    } best_t;

endpackage

`default_nettype wire

/* source/sw_settings.svh */
`ifndef SW_SETTINGS_SVH
`define SW_SETTINGS_SVH

// job framing
`define Q_LEN          8
`define R_LEN          16

// index and score widths
`define ROW_W          3
`define COL_W          4
`define SCORE_W        8

// input FIFO depth, also the sender's starting credit count
// must be a power of two
`define FIFO_DEPTH     4

// affine-gap scoring
`define MATCH_SCORE    2
`define MISMATCH_SCORE (-1)
`define GAP_OPEN       1
`define GAP_EXTEND     1

`endif
